/* hdl/vga_timing_pkg.sv */
package vga_timing_pkg;

    // Counter width shared by hcount and vcount
    localparam int COUNT_W = 12;

    // Visible raster is 1024 x 768
    localparam int H_LAST = 1023;
    localparam int V_LAST = 767;

    typedef logic [COUNT_W-1:0] count_t;

    // Beam position and sync/blank flags for one pixel
    typedef struct packed {
        count_t hcount;
        count_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
    } vga_timing_t;

endpackage

/* hdl/scene_pkg.sv */
package scene_pkg;

    // 4-4-4 colour, red in the top nibble
    typedef logic [11:0] rgb_t;

    localparam rgb_t COLOR_BLACK  = 12'h0_0_0;
    localparam rgb_t COLOR_WHITE  = 12'hf_f_f;
    localparam rgb_t COLOR_YELLOW = 12'hf_f_0;
    localparam rgb_t COLOR_RED    = 12'hf_0_0;
    localparam rgb_t COLOR_GREEN  = 12'h0_f_0;
    localparam rgb_t COLOR_BLUE   = 12'h0_0_f;

    // Codes 2 to 7 are not painted and hold the last colour
    typedef logic [2:0] screen_mode_t;

    localparam screen_mode_t MODE_MENU = 3'd0;
    localparam screen_mode_t MODE_GAME = 3'd1;

    // Inside when lo < coord <= hi on both axes
    typedef struct packed {
        vga_timing_pkg::count_t x_lo;
        vga_timing_pkg::count_t x_hi;
        vga_timing_pkg::count_t y_lo;
        vga_timing_pkg::count_t y_hi;
    } rect_t;

    localparam int MENU_RECT_COUNT = 14;

    // Letters of the MENU caption, order x_lo, x_hi, y_lo, y_hi
    localparam rect_t MENU_RECTS [MENU_RECT_COUNT] = '{
        // M
        '{12'd170, 12'd210, 12'd90,  12'd250},
        '{12'd170, 12'd370, 12'd50,  12'd90},
        '{12'd250, 12'd290, 12'd90,  12'd250},
        '{12'd330, 12'd370, 12'd90,  12'd250},
        // E
        '{12'd420, 12'd460, 12'd50,  12'd250},
        '{12'd460, 12'd500, 12'd50,  12'd90},
        '{12'd460, 12'd500, 12'd130, 12'd170},
        '{12'd460, 12'd500, 12'd210, 12'd250},
        // N
        '{12'd550, 12'd590, 12'd90,  12'd250},
        '{12'd550, 12'd670, 12'd50,  12'd90},
        '{12'd630, 12'd670, 12'd90,  12'd250},
        // U
        '{12'd720, 12'd760, 12'd50,  12'd210},
        '{12'd720, 12'd840, 12'd210, 12'd250},
        '{12'd800, 12'd840, 12'd50,  12'd210}
    };

    // Play arena, the frame sits outside these lines
    localparam vga_timing_pkg::count_t ARENA_TOP    = 12'd317;
    localparam vga_timing_pkg::count_t ARENA_BOTTOM = 12'd617;
    localparam vga_timing_pkg::count_t ARENA_LEFT   = 12'd361;
    localparam vga_timing_pkg::count_t ARENA_RIGHT  = 12'd661;
    localparam vga_timing_pkg::count_t ARENA_BORDER = 12'd10;

    // Result of the frame painter for one pixel
    typedef struct packed {
        logic edge_hit;
        rgb_t edge_rgb;
        logic arena_hit;
    } frame_hit_t;

endpackage

/* hdl/frame_painter.sv */
`timescale 1ns/1ps

module frame_painter (
    input  vga_timing_pkg::count_t hcount,
    input  vga_timing_pkg::count_t vcount,
    output scene_pkg::frame_hit_t  hit
);

    logic frame_rows;
    logic inner_cols;
    logic left_bar;
    logic right_bar;
    logic top_bar;
    logic bottom_bar;

    // Rows covered by the side bars including the border
    assign frame_rows = (vcount >= scene_pkg::ARENA_TOP - scene_pkg::ARENA_BORDER) &&
                        (vcount <  scene_pkg::ARENA_BOTTOM + scene_pkg::ARENA_BORDER);

    // Columns between the side bars
    assign inner_cols = (hcount >= scene_pkg::ARENA_LEFT) &&
                        (hcount <  scene_pkg::ARENA_RIGHT);

    assign left_bar = frame_rows &&
                      (hcount >= scene_pkg::ARENA_LEFT - scene_pkg::ARENA_BORDER) &&
                      (hcount <  scene_pkg::ARENA_LEFT);

    assign right_bar = frame_rows &&
                       (hcount >= scene_pkg::ARENA_RIGHT) &&
                       (hcount <  scene_pkg::ARENA_RIGHT + scene_pkg::ARENA_BORDER);

    assign top_bar = inner_cols &&
                     (vcount >= scene_pkg::ARENA_TOP - scene_pkg::ARENA_BORDER) &&
                     (vcount <  scene_pkg::ARENA_TOP);

    assign bottom_bar = inner_cols &&
                        (vcount >= scene_pkg::ARENA_BOTTOM) &&
                        (vcount <  scene_pkg::ARENA_BOTTOM + scene_pkg::ARENA_BORDER);

    // Top and bottom edges win over the side columns
    always_comb begin
        hit.arena_hit = left_bar || right_bar || top_bar || bottom_bar;
        hit.edge_hit  = 1'b1;
        if (vcount == 0) begin
            hit.edge_rgb = scene_pkg::COLOR_YELLOW;
        end else if (vcount == vga_timing_pkg::V_LAST) begin
            hit.edge_rgb = scene_pkg::COLOR_RED;
        end else if (hcount == 0) begin
            hit.edge_rgb = scene_pkg::COLOR_GREEN;
        end else if (hcount == vga_timing_pkg::H_LAST) begin
            hit.edge_rgb = scene_pkg::COLOR_BLUE;
        end else begin
            hit.edge_hit = 1'b0;
            hit.edge_rgb = scene_pkg::COLOR_BLACK;
        end
    end

endmodule

/* hdl/menu_caption_painter.sv */
`timescale 1ns/1ps

module menu_caption_painter (
    input  vga_timing_pkg::count_t hcount,
    input  vga_timing_pkg::count_t vcount,
    output logic                   hit
);

    logic [scene_pkg::MENU_RECT_COUNT-1:0] rect_hit;

    // One comparator set per letter rectangle
    always_comb begin
        for (int i = 0; i < scene_pkg::MENU_RECT_COUNT; i++) begin
            rect_hit[i] = (hcount >  scene_pkg::MENU_RECTS[i].x_lo) &&
                          (hcount <= scene_pkg::MENU_RECTS[i].x_hi) &&
                          (vcount >  scene_pkg::MENU_RECTS[i].y_lo) &&
                          (vcount <= scene_pkg::MENU_RECTS[i].y_hi);
        end
    end

    // Rectangles overlap at letter joints, any hit counts
    assign hit = |rect_hit;

endmodule

/* hdl/pixel_compositor.sv */
`timescale 1ns/1ps

module pixel_compositor (
    input  logic                         clk,
    input  logic                         rst,
    input  vga_timing_pkg::vga_timing_t  timing_in,
    input  scene_pkg::screen_mode_t      mode,
    input  scene_pkg::frame_hit_t        frame_hit,
    input  logic                         caption_hit,
    output vga_timing_pkg::vga_timing_t  timing_out,
    output scene_pkg::rgb_t              rgb
);

    scene_pkg::rgb_t rgb_nxt;
    logic            mode_known;
    logic            shape_hit;
    logic            blank;

    assign blank = timing_in.hblnk || timing_in.vblnk;

    // Pick the shape that belongs to the current screen
    always_comb begin
        mode_known = 1'b1;
        shape_hit  = 1'b0;
        case (mode)
            scene_pkg::MODE_MENU: begin
                shape_hit = caption_hit;
            end
            scene_pkg::MODE_GAME: begin
                shape_hit = frame_hit.arena_hit;
            end
            default: begin
                mode_known = 1'b0;
            end
        endcase
    end

    // Colour priority, first match wins
    always_comb begin
        if (!mode_known) begin
            // Unknown screen keeps the last painted colour
            rgb_nxt = rgb;
        end else if (blank) begin
            rgb_nxt = scene_pkg::COLOR_BLACK;
        end else if (frame_hit.edge_hit) begin
            rgb_nxt = frame_hit.edge_rgb;
        end else if (shape_hit) begin
            rgb_nxt = scene_pkg::COLOR_WHITE;
        end else begin
            rgb_nxt = scene_pkg::COLOR_BLACK;
        end
    end

    // Timing and colour leave together, one cycle after entry
    always_ff @(posedge clk) begin
        if (rst) begin
            timing_out <= '0;
            rgb        <= scene_pkg::COLOR_BLACK;
        end else begin
            timing_out <= timing_in;
            rgb        <= rgb_nxt;
        end
    end

endmodule

/* hdl/draw_background.sv */
`timescale 1ns/1ps

module draw_background (
    input  logic                         clk,
    input  logic                         rst,
    input  vga_timing_pkg::vga_timing_t  timing_in,
    input  scene_pkg::screen_mode_t      mode,
    output vga_timing_pkg::vga_timing_t  timing_out,
    output scene_pkg::rgb_t              rgb
);

    scene_pkg::frame_hit_t frame_hit;
    logic                  caption_hit;

    // Both painters look at the incoming pixel in parallel
    frame_painter i_frame_painter (
        .hcount (timing_in.hcount),
        .vcount (timing_in.vcount),
        .hit    (frame_hit)
    );

    menu_caption_painter i_menu_caption_painter (
        .hcount (timing_in.hcount),
        .vcount (timing_in.vcount),
        .hit    (caption_hit)
    );

    // Mode decides which painter result is shown
    pixel_compositor i_pixel_compositor (
        .clk         (clk),
        .rst         (rst),
        .timing_in   (timing_in),
        .mode        (mode),
        .frame_hit   (frame_hit),
        .caption_hit (caption_hit),
        .timing_out  (timing_out),
        .rgb         (rgb)
    );

endmodule

/* include/draw_background_checks.svh */
`ifndef DRAW_BACKGROUND_CHECKS_SVH
`define DRAW_BACKGROUND_CHECKS_SVH

// Stops the run on the first mismatch
task automatic report_failure(
    input string signal_name,
    input string expected,
    input string actual
);
    $display("ERROR at %0t ns: %s expected %s, got %s",
             $time, signal_name, expected, actual);
    $display("Test FAILED");
    $fatal(1, "Mismatch on %s", signal_name);
endtask

// Readable form of a timing struct for error lines
function automatic string timing_to_string(input vga_timing_pkg::vga_timing_t t);
    return $sformatf("{hcount=%0d vcount=%0d hsync=%0b vsync=%0b hblnk=%0b vblnk=%0b}",
                     t.hcount, t.vcount, t.hsync, t.vsync, t.hblnk, t.vblnk);
endfunction

task automatic check_rgb(
    input string           signal_name,
    input scene_pkg::rgb_t expected,
    input scene_pkg::rgb_t actual
);
    // Case inequality so X or Z on the output also fails
    if (actual !== expected) begin
        report_failure(signal_name,
                       $sformatf("12'h%03h", expected),
                       $sformatf("12'h%03h", actual));
    end
endtask

task automatic check_timing(
    input string                       signal_name,
    input vga_timing_pkg::vga_timing_t expected,
    input vga_timing_pkg::vga_timing_t actual
);
    if (actual !== expected) begin
        report_failure(signal_name,
                       timing_to_string(expected),
                       timing_to_string(actual));
    end
endtask

`endif

/* dv/draw_background_tb.sv */
`timescale 1ns/1ps

module draw_background_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;

    // Pixel counts per test size the watchdog
    localparam int STREAM_LEN     = 32;
    localparam int BLANK_PIXELS   = 18;
    localparam int EDGE_PIXELS    = 8;
    localparam int CAPTION_PIXELS = scene_pkg::MENU_RECT_COUNT * 5;
    localparam int MENU_RANDOM    = 24;
    localparam int ARENA_PIXELS   = 39;
    localparam int HOLD_PIXELS    = 11;
    localparam int TOTAL_PIXELS   = STREAM_LEN + BLANK_PIXELS + EDGE_PIXELS + CAPTION_PIXELS +
                                    MENU_RANDOM + ARENA_PIXELS + HOLD_PIXELS;
    localparam int WATCHDOG_NS    = 2 * TOTAL_PIXELS * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    // Corners of the left, top, bottom and right arena bars
    localparam int BAR_X [16] = '{351, 360, 351, 360, 361, 660, 361, 660,
                                  361, 660, 361, 660, 661, 670, 661, 670};
    localparam int BAR_Y [16] = '{307, 307, 626, 626, 307, 307, 316, 316,
                                  617, 617, 626, 626, 307, 307, 626, 626};

    // One step outside the frame on sides and corners
    localparam int OUT_X [6] = '{350, 671, 500, 500, 350, 671};
    localparam int OUT_Y [6] = '{400, 400, 306, 627, 306, 627};

    logic                        clk = 1'b0;
    logic                        rst;
    vga_timing_pkg::vga_timing_t timing_in;
    scene_pkg::screen_mode_t     mode;
    vga_timing_pkg::vga_timing_t timing_out;
    scene_pkg::rgb_t             rgb;

    integer          seed;
    scene_pkg::rgb_t model_rgb;

    `include "draw_background_checks.svh"

    draw_background i_dut (
        .clk        (clk),
        .rst        (rst),
        .timing_in  (timing_in),
        .mode       (mode),
        .timing_out (timing_out),
        .rgb        (rgb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $fatal(1, "Watchdog timeout");
    end

    function automatic vga_timing_pkg::vga_timing_t make_pixel(
        input int   x,
        input int   y,
        input logic hb,
        input logic vb
    );
        vga_timing_pkg::vga_timing_t t;
        t        = '0;
        t.hcount = x[11:0];
        t.vcount = y[11:0];
        t.hblnk  = hb;
        t.vblnk  = vb;
        return t;
    endfunction

    function automatic bit in_caption(input int x, input int y);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < scene_pkg::MENU_RECT_COUNT; i++) begin
            if (x > scene_pkg::MENU_RECTS[i].x_lo && x <= scene_pkg::MENU_RECTS[i].x_hi &&
                y > scene_pkg::MENU_RECTS[i].y_lo && y <= scene_pkg::MENU_RECTS[i].y_hi) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Frame is the outer box minus the arena itself
    function automatic bit in_arena_frame(input int x, input int y);
        bit outer;
        bit inner;
        outer = x >= scene_pkg::ARENA_LEFT - scene_pkg::ARENA_BORDER &&
                x <= scene_pkg::ARENA_RIGHT + scene_pkg::ARENA_BORDER - 1 &&
                y >= scene_pkg::ARENA_TOP - scene_pkg::ARENA_BORDER &&
                y <= scene_pkg::ARENA_BOTTOM + scene_pkg::ARENA_BORDER - 1;
        inner = x >= scene_pkg::ARENA_LEFT && x <= scene_pkg::ARENA_RIGHT - 1 &&
                y >= scene_pkg::ARENA_TOP && y <= scene_pkg::ARENA_BOTTOM - 1;
        return outer && !inner;
    endfunction

    function automatic scene_pkg::rgb_t model_colour(
        input vga_timing_pkg::vga_timing_t t,
        input scene_pkg::screen_mode_t     m,
        input scene_pkg::rgb_t             prev
    );
        if (m != scene_pkg::MODE_MENU && m != scene_pkg::MODE_GAME) return prev;
        if (t.hblnk || t.vblnk) return scene_pkg::COLOR_BLACK;
        if (t.vcount == 0) return scene_pkg::COLOR_YELLOW;
        if (t.vcount == vga_timing_pkg::V_LAST) return scene_pkg::COLOR_RED;
        if (t.hcount == 0) return scene_pkg::COLOR_GREEN;
        if (t.hcount == vga_timing_pkg::H_LAST) return scene_pkg::COLOR_BLUE;
        if (m == scene_pkg::MODE_MENU && in_caption(t.hcount, t.vcount)) begin
            return scene_pkg::COLOR_WHITE;
        end
        if (m == scene_pkg::MODE_GAME && in_arena_frame(t.hcount, t.vcount)) begin
            return scene_pkg::COLOR_WHITE;
        end
        return scene_pkg::COLOR_BLACK;
    endfunction

    // Drive one pixel and check it after the capture edge
    task automatic send_pixel(
        input vga_timing_pkg::vga_timing_t t,
        input scene_pkg::screen_mode_t     m,
        input scene_pkg::rgb_t             exp_rgb
    );
        @(posedge clk);
        timing_in <= t;
        mode      <= m;
        @(posedge clk);
        @(negedge clk);
        check_timing("timing_out", t, timing_out);
        check_rgb("rgb", exp_rgb, rgb);
        model_rgb = exp_rgb;
    endtask

    task automatic send_modelled(input int x, input int y, input scene_pkg::screen_mode_t m);
        vga_timing_pkg::vga_timing_t t;
        t = make_pixel(x, y, 1'b0, 1'b0);
        send_pixel(t, m, model_colour(t, m, model_rgb));
    endtask

    task automatic reset_clears_outputs();
        @(negedge clk);
        check_timing("timing_out", '0, timing_out);
        check_rgb("rgb", scene_pkg::COLOR_BLACK, rgb);
        model_rgb = scene_pkg::COLOR_BLACK;
    endtask

    // New pixel every cycle with each checked one cycle later
    task automatic stream_random_timing();
        vga_timing_pkg::vga_timing_t sent [STREAM_LEN];
        scene_pkg::screen_mode_t     modes [STREAM_LEN];
        scene_pkg::rgb_t             exp_rgb;
        logic [31:0]                 r;
        for (int i = 0; i < STREAM_LEN; i++) begin
            r        = $random(seed);
            sent[i]  = r[27:0];
            modes[i] = {2'b00, r[28]};
        end
        for (int i = 0; i <= STREAM_LEN; i++) begin
            @(posedge clk);
            if (i < STREAM_LEN) begin
                timing_in <= sent[i];
                mode      <= modes[i];
            end
            @(negedge clk);
            if (i > 0) begin
                exp_rgb = model_colour(sent[i-1], modes[i-1], model_rgb);
                check_timing("timing_out", sent[i-1], timing_out);
                check_rgb("rgb", exp_rgb, rgb);
                model_rgb = exp_rgb;
            end
        end
    endtask

    task automatic blanking_forces_black();
        scene_pkg::screen_mode_t m;
        for (int mi = 0; mi < 2; mi++) begin
            m = mi[2:0];
            for (int b = 1; b < 4; b++) begin
                // Caption pixel, arena bar pixel and screen corner
                send_pixel(make_pixel(200, 100, b[0], b[1]), m, scene_pkg::COLOR_BLACK);
                send_pixel(make_pixel(355, 400, b[0], b[1]), m, scene_pkg::COLOR_BLACK);
                send_pixel(make_pixel(0, 0, b[0], b[1]), m, scene_pkg::COLOR_BLACK);
            end
        end
    endtask

    task automatic menu_edge_colours();
        scene_pkg::screen_mode_t m;
        m = scene_pkg::MODE_MENU;
        send_pixel(make_pixel(0, 0, 1'b0, 1'b0), m, scene_pkg::COLOR_YELLOW);
        send_pixel(make_pixel(1023, 0, 1'b0, 1'b0), m, scene_pkg::COLOR_YELLOW);
        send_pixel(make_pixel(500, 0, 1'b0, 1'b0), m, scene_pkg::COLOR_YELLOW);
        send_pixel(make_pixel(0, 767, 1'b0, 1'b0), m, scene_pkg::COLOR_RED);
        send_pixel(make_pixel(1023, 767, 1'b0, 1'b0), m, scene_pkg::COLOR_RED);
        send_pixel(make_pixel(500, 767, 1'b0, 1'b0), m, scene_pkg::COLOR_RED);
        send_pixel(make_pixel(0, 400, 1'b0, 1'b0), m, scene_pkg::COLOR_GREEN);
        send_pixel(make_pixel(1023, 400, 1'b0, 1'b0), m, scene_pkg::COLOR_BLUE);
    endtask

    task automatic menu_caption_bounds();
        scene_pkg::rect_t        r;
        scene_pkg::screen_mode_t m;
        m = scene_pkg::MODE_MENU;
        for (int i = 0; i < scene_pkg::MENU_RECT_COUNT; i++) begin
            r = scene_pkg::MENU_RECTS[i];
            // Lowest and highest inner corners
            send_pixel(make_pixel(r.x_lo + 1, r.y_lo + 1, 1'b0, 1'b0), m, scene_pkg::COLOR_WHITE);
            send_pixel(make_pixel(r.x_hi, r.y_hi, 1'b0, 1'b0), m, scene_pkg::COLOR_WHITE);
            // Neighbouring letters may overlap so the model decides
            send_modelled(r.x_lo, r.y_lo + 1, m);
            send_modelled(r.x_hi + 1, r.y_hi, m);
            send_modelled(r.x_lo + 1, r.y_hi + 1, m);
        end
    endtask

    task automatic menu_random_pixels();
        logic [31:0] rx;
        logic [31:0] ry;
        for (int i = 0; i < MENU_RANDOM; i++) begin
            rx = $random(seed);
            ry = $random(seed);
            send_modelled(rx % 1024, ry % 768, scene_pkg::MODE_MENU);
        end
    endtask

    task automatic game_arena_frame();
        scene_pkg::screen_mode_t m;
        m = scene_pkg::MODE_GAME;
        for (int i = 0; i < 16; i++) begin
            send_pixel(make_pixel(BAR_X[i], BAR_Y[i], 1'b0, 1'b0), m, scene_pkg::COLOR_WHITE);
        end
        for (int i = 0; i < 6; i++) begin
            send_pixel(make_pixel(OUT_X[i], OUT_Y[i], 1'b0, 1'b0), m, scene_pkg::COLOR_BLACK);
        end
        send_pixel(make_pixel(361, 317, 1'b0, 1'b0), m, scene_pkg::COLOR_BLACK);
        send_pixel(make_pixel(660, 616, 1'b0, 1'b0), m, scene_pkg::COLOR_BLACK);
        send_pixel(make_pixel(511, 467, 1'b0, 1'b0), m, scene_pkg::COLOR_BLACK);
        // Caption is not drawn on the game screen
        for (int i = 0; i < scene_pkg::MENU_RECT_COUNT; i++) begin
            send_pixel(make_pixel(scene_pkg::MENU_RECTS[i].x_hi, scene_pkg::MENU_RECTS[i].y_hi,
                                  1'b0, 1'b0), m, scene_pkg::COLOR_BLACK);
        end
    endtask

    task automatic unsupported_mode_hold();
        send_pixel(make_pixel(355, 400, 1'b0, 1'b0), scene_pkg::MODE_GAME, scene_pkg::COLOR_WHITE);
        for (int code = 2; code < 8; code++) begin
            send_pixel(make_pixel(100 * code, 60 * code, code[0], 1'b0), code[2:0],
                       scene_pkg::COLOR_WHITE);
        end
        send_pixel(make_pixel(0, 0, 1'b0, 1'b0), scene_pkg::MODE_MENU, scene_pkg::COLOR_YELLOW);
        send_pixel(make_pixel(500, 500, 1'b0, 1'b0), 3'd7, scene_pkg::COLOR_YELLOW);
        send_pixel(make_pixel(0, 767, 1'b1, 1'b1), 3'd3, scene_pkg::COLOR_YELLOW);
        send_pixel(make_pixel(500, 500, 1'b0, 1'b0), scene_pkg::MODE_GAME, scene_pkg::COLOR_BLACK);
    endtask

    initial begin
        seed      = 32'h9a50a1ed;
        model_rgb = scene_pkg::COLOR_BLACK;
        rst       = 1'b1;
        // Non-zero pattern so reset has something to clear
        timing_in = make_pixel(355, 400, 1'b0, 1'b0);
        timing_in.hsync = 1'b1;
        timing_in.vsync = 1'b1;
        mode      = scene_pkg::MODE_GAME;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        reset_clears_outputs();
        stream_random_timing();
        blanking_forces_black();
        menu_edge_colours();
        menu_caption_bounds();
        menu_random_pixels();
        game_arena_frame();
        unsupported_mode_hold();

        $display("Test OK");
        $finish;
    end

endmodule

/* draw_background.f */
+incdir+include
hdl/vga_timing_pkg.sv
hdl/scene_pkg.sv
hdl/frame_painter.sv
hdl/menu_caption_painter.sv
hdl/pixel_compositor.sv
hdl/draw_background.sv
dv/draw_background_tb.sv
